// ==== design/corr_pkg.sv ====
package corr_pkg;

   //////////////////////////////////////////////////
   // widths
   //////////////////////////////////////////////////

   // signed width of one real or imaginary part
   localparam int DATA_WIDTH = 8;

   // largest block length the accumulators are sized for
   localparam int N_MAX = 64;

   // full product of two parts, no rounding
   localparam int PROD_WIDTH = 2 * DATA_WIDTH;

   // product, one bit for the re/im add, log2 of the step count
   localparam int ACC_WIDTH = PROD_WIDTH + 1 + $clog2(N_MAX);

   // pe tag carried with every output beat
   localparam int PE_IDX_WIDTH = 8;

   //////////////////////////////////////////////////
   // types
   //////////////////////////////////////////////////

   // one complex word, samples and coefficients alike
   typedef struct packed {
      logic signed [DATA_WIDTH-1:0] re;
      logic signed [DATA_WIDTH-1:0] im;
   } cplx_t;

   // full precision accumulator pair
   typedef struct packed {
      logic signed [ACC_WIDTH-1:0] re;
      logic signed [ACC_WIDTH-1:0] im;
   } acc_t;

   // output beat, value tagged with its pe
   typedef struct packed {
      logic [PE_IDX_WIDTH-1:0] pe_idx;
      acc_t                    value;
   } result_t;

endpackage

// ==== design/credit_ingress.sv ====
module credit_ingress #(
   parameter int INGRESS_DEPTH = 8
) (
   input  logic            clk,
   input  logic            rst,
   input  logic            in_valid,
   input  corr_pkg::cplx_t in_data,
   output logic            in_credit,
   output logic            fifo_valid,
   output corr_pkg::cplx_t fifo_data,
   input  logic            fifo_pop
);
   import corr_pkg::*;

   localparam int PTR_W = (INGRESS_DEPTH > 1) ? $clog2(INGRESS_DEPTH) : 1;
   localparam int CNT_W = $clog2(INGRESS_DEPTH + 1);

   // circular storage of the words
   cplx_t mem [INGRESS_DEPTH];

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             full;
   logic             wr_en;
   logic             rd_en;

   assign full  = (count == CNT_W'(INGRESS_DEPTH));
   assign wr_en = in_valid && !full;
   assign rd_en = fifo_pop && fifo_valid;

   // count is registered, so valid shows one cycle after the write
   assign fifo_valid = (count != '0);
   assign fifo_data  = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= in_data;
      end
   end

   //////////////////////////////////////////////////
   // pointers, fill level, credit return
   //////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         count     <= '0;
         in_credit <= 1'b0;
      end else begin
         if (wr_en) begin
            wr_ptr <= (wr_ptr == PTR_W'(INGRESS_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= (rd_ptr == PTR_W'(INGRESS_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         // one credit back per word that leaves
         in_credit <= rd_en;
      end
   end

   //////////////////////////////////////////////////
   // checks
   //////////////////////////////////////////////////

   // upstream only sends with a credit in hand, so full means it overran
   a_no_overrun : assert property (@(posedge clk) disable iff (rst)
      in_valid |-> !full)
      else $error("credit_ingress: write while full");

   a_no_underrun : assert property (@(posedge clk) disable iff (rst)
      fifo_pop |-> fifo_valid)
      else $error("credit_ingress: pop while empty");

endmodule

// ==== design/sample_ring.sv ====
module sample_ring #(
   parameter int PE_NUM  = 4,
   parameter int REG_NUM = 4
) (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         fifo_valid,
   input  corr_pkg::cplx_t              fifo_data,
   output logic                         fifo_pop,
   input  logic                         egress_free,
   output logic                         step_valid,
   output logic                         step_first,
   output logic                         step_last,
   output corr_pkg::cplx_t [PE_NUM-1:0] tap_data,
   output corr_pkg::cplx_t              coeff
);
   import corr_pkg::*;

   localparam int N     = PE_NUM * REG_NUM;
   localparam int CNT_W = (N > 1) ? $clog2(N) : 1;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_LOAD_Y,
      ST_LOAD_H,
      ST_WAIT,
      ST_ROTATE
   } state_t;

   state_t state;
   state_t state_nxt;

   logic [CNT_W-1:0] load_cnt;
   logic [CNT_W-1:0] step_cnt;
   logic             load_last;
   logic             rot_last;

   // ring of N samples, position k holds y[k] after loading
   cplx_t [N-1:0] ring;
   cplx_t         ring_in;
   logic          ring_shift;

   // one coefficient per step
   cplx_t coeff_mem [N];

   assign fifo_pop  = fifo_valid && (state == ST_LOAD_Y || state == ST_LOAD_H);
   assign load_last = (load_cnt == CNT_W'(N - 1));
   assign rot_last  = (step_cnt == CNT_W'(N - 1));

   //////////////////////////////////////////////////
   // fsm
   //////////////////////////////////////////////////
   always_comb begin
      state_nxt = state;
      case (state)
         ST_IDLE:   if (fifo_valid) state_nxt = ST_LOAD_Y;
         ST_LOAD_Y: if (fifo_pop && load_last) state_nxt = ST_LOAD_H;
         // skip wait when the egress is already empty
         ST_LOAD_H: begin
            if (fifo_pop && load_last) begin
               state_nxt = egress_free ? ST_ROTATE : ST_WAIT;
            end
         end
         ST_WAIT:   if (egress_free) state_nxt = ST_ROTATE;
         ST_ROTATE: if (rot_last) state_nxt = ST_IDLE;
         default:   state_nxt = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= ST_IDLE;
         load_cnt <= '0;
         step_cnt <= '0;
      end else begin
         state <= state_nxt;
         // load count runs 0..N-1 once per phase
         if (fifo_pop) begin
            load_cnt <= load_last ? '0 : load_cnt + 1'b1;
         end
         if (state == ST_ROTATE) begin
            step_cnt <= rot_last ? '0 : step_cnt + 1'b1;
         end
      end
   end

   //////////////////////////////////////////////////
   // ring and coefficient store
   //////////////////////////////////////////////////

   // same shift for loading and rotating, top entry is refilled
   assign ring_in    = (state == ST_LOAD_Y) ? fifo_data : ring[0];
   assign ring_shift = (state == ST_LOAD_Y && fifo_pop) || (state == ST_ROTATE);

   always_ff @(posedge clk) begin
      if (ring_shift) begin
         ring <= {ring_in, ring[N-1:1]};
      end
      if (state == ST_LOAD_H && fifo_pop) begin
         coeff_mem[load_cnt] <= fifo_data;
      end
   end

   // after t steps, position k holds y[(k+t) mod N]
   for (genvar p = 0; p < PE_NUM; p++) begin : g_tap
      assign tap_data[p] = ring[p * REG_NUM];
   end

   assign coeff      = coeff_mem[step_cnt];
   assign step_valid = (state == ST_ROTATE);
   assign step_first = step_valid && (step_cnt == '0);
   assign step_last  = step_valid && rot_last;

   // rotation is one unbroken burst of N steps
   a_rot_len : assert property (@(posedge clk) disable iff (rst)
      $rose(step_valid) |-> step_valid [*N] ##1 !step_valid)
      else $error("sample_ring: rotation burst is not N cycles");

endmodule

// ==== design/pe_array.sv ====
module pe_array #(
   parameter int PE_NUM = 4
) (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        step_valid,
   input  logic                        step_first,
   input  logic                        step_last,
   input  corr_pkg::cplx_t [PE_NUM-1:0] tap_data,
   input  corr_pkg::cplx_t             coeff,
   output logic                        blk_valid,
   output corr_pkg::acc_t [PE_NUM-1:0] blk_data
);
   import corr_pkg::*;

   //////////////////////////////////////////////////
   // mac elements
   //////////////////////////////////////////////////
   for (genvar p = 0; p < PE_NUM; p++) begin : g_pe
      // four partial products, each full width
      logic signed [PROD_WIDTH-1:0] rr;
      logic signed [PROD_WIDTH-1:0] ii;
      logic signed [PROD_WIDTH-1:0] ri;
      logic signed [PROD_WIDTH-1:0] ir;
      // complex product sign extended to accumulator width
      logic signed [ACC_WIDTH-1:0]  prod_re;
      logic signed [ACC_WIDTH-1:0]  prod_im;
      acc_t                         acc_q;

      assign rr = tap_data[p].re * coeff.re;
      assign ii = tap_data[p].im * coeff.im;
      assign ri = tap_data[p].re * coeff.im;
      assign ir = tap_data[p].im * coeff.re;

      // re = ar*br - ai*bi, im = ar*bi + ai*br
      assign prod_re = rr - ii;
      assign prod_im = ri + ir;

      // first step restarts the sum, the rest add on
      always_ff @(posedge clk) begin
         if (step_valid) begin
            if (step_first) begin
               acc_q.re <= prod_re;
               acc_q.im <= prod_im;
            end else begin
               acc_q.re <= acc_q.re + prod_re;
               acc_q.im <= acc_q.im + prod_im;
            end
         end
      end

      assign blk_data[p] = acc_q;
   end

   //////////////////////////////////////////////////
   // block done
   //////////////////////////////////////////////////

   // sums are final the cycle after the last step
   always_ff @(posedge clk) begin
      if (rst) begin
         blk_valid <= 1'b0;
      end else begin
         blk_valid <= step_valid && step_last;
      end
   end

endmodule

// ==== design/result_egress.sv ====
module result_egress #(
   parameter int PE_NUM = 4
) (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        blk_valid,
   input  corr_pkg::acc_t [PE_NUM-1:0] blk_data,
   output logic                        egress_free,
   output logic                        out_valid,
   output corr_pkg::result_t           out_data,
   input  logic                        out_credit
);
   import corr_pkg::*;

   localparam int IDX_W  = (PE_NUM > 1) ? $clog2(PE_NUM) : 1;
   localparam int CRED_W = 8;

   // holding registers for one block
   acc_t [PE_NUM-1:0] blk_q;
   logic              full;
   logic [IDX_W-1:0]  send_idx;
   logic [CRED_W-1:0] credit_cnt;
   logic              send;
   logic              send_last;

   // one beat per cycle while a credit is held
   assign send      = full && (credit_cnt != '0);
   assign send_last = (send_idx == IDX_W'(PE_NUM - 1));

   // free once the last beat has left the port
   assign egress_free = !full && !out_valid;

   always_ff @(posedge clk) begin
      if (blk_valid) begin
         blk_q <= blk_data;
      end
      if (send) begin
         out_data.pe_idx <= PE_IDX_WIDTH'(send_idx);
         out_data.value  <= blk_q[send_idx];
      end
   end

   //////////////////////////////////////////////////
   // send control and credit count
   //////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (rst) begin
         full       <= 1'b0;
         send_idx   <= '0;
         credit_cnt <= '0;
         out_valid  <= 1'b0;
      end else begin
         out_valid  <= send;
         credit_cnt <= credit_cnt + CRED_W'(out_credit) - CRED_W'(send);
         if (blk_valid) begin
            full <= 1'b1;
         end else if (send && send_last) begin
            full <= 1'b0;
         end
         if (send) begin
            send_idx <= send_last ? '0 : send_idx + 1'b1;
         end
      end
   end

   // a grant landing on a saturated counter would be lost
   a_credit_wrap : assert property (@(posedge clk) disable iff (rst)
      (out_credit && !send) |-> (credit_cnt != '1))
      else $error("result_egress: credit counter overflow");

   // ring must wait for egress_free before rotating
   a_no_overwrite : assert property (@(posedge clk) disable iff (rst)
      blk_valid |-> !full)
      else $error("result_egress: block arrived while holding one");

endmodule

// ==== design/corr_top.sv ====
module corr_top #(
   parameter int PE_NUM        = 4,
   parameter int REG_NUM       = 4,
   parameter int INGRESS_DEPTH = 8
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              in_valid,
   input  corr_pkg::cplx_t   in_data,
   output logic              in_credit,
   output logic              out_valid,
   output corr_pkg::result_t out_data,
   input  logic              out_credit
);
   import corr_pkg::*;

   //////////////////////////////////////////////////
   // stage links
   //////////////////////////////////////////////////

   // ingress to ring
   logic  fifo_valid;
   cplx_t fifo_data;
   logic  fifo_pop;

   // ring to pe array
   logic               step_valid;
   logic               step_first;
   logic               step_last;
   cplx_t [PE_NUM-1:0] tap_data;
   cplx_t              coeff;

   // pe array to egress, and egress back to ring
   logic              blk_valid;
   acc_t [PE_NUM-1:0] blk_data;
   logic              egress_free;

   credit_ingress #(
      .INGRESS_DEPTH (INGRESS_DEPTH)
   ) u_ingress (
      .clk        (clk),
      .rst        (rst),
      .in_valid   (in_valid),
      .in_data    (in_data),
      .in_credit  (in_credit),
      .fifo_valid (fifo_valid),
      .fifo_data  (fifo_data),
      .fifo_pop   (fifo_pop)
   );

   sample_ring #(
      .PE_NUM  (PE_NUM),
      .REG_NUM (REG_NUM)
   ) u_ring (
      .clk         (clk),
      .rst         (rst),
      .fifo_valid  (fifo_valid),
      .fifo_data   (fifo_data),
      .fifo_pop    (fifo_pop),
      .egress_free (egress_free),
      .step_valid  (step_valid),
      .step_first  (step_first),
      .step_last   (step_last),
      .tap_data    (tap_data),
      .coeff       (coeff)
   );

   pe_array #(
      .PE_NUM (PE_NUM)
   ) u_pe (
      .clk        (clk),
      .rst        (rst),
      .step_valid (step_valid),
      .step_first (step_first),
      .step_last  (step_last),
      .tap_data   (tap_data),
      .coeff      (coeff),
      .blk_valid  (blk_valid),
      .blk_data   (blk_data)
   );

   result_egress #(
      .PE_NUM (PE_NUM)
   ) u_egress (
      .clk         (clk),
      .rst         (rst),
      .blk_valid   (blk_valid),
      .blk_data    (blk_data),
      .egress_free (egress_free),
      .out_valid   (out_valid),
      .out_data    (out_data),
      .out_credit  (out_credit)
   );

endmodule

// ==== dv/corr_tb.sv ====
module corr_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import corr_pkg::*;

   localparam int PE_NUM        = 4;
   localparam int REG_NUM       = 4;
   localparam int INGRESS_DEPTH = 8;
   localparam int N             = PE_NUM * REG_NUM;
   localparam int WORDS         = 2 * N;
   // most unused grants the sink hands out
   localparam int OUT_CREDIT_CAP = 2;

   logic    clk;
   logic    rst;
   logic    in_valid;
   cplx_t   in_data;
   logic    in_credit;
   logic    out_valid;
   result_t out_data;
   logic    out_credit;

   // stimulus words and expected sums, in file order
   cplx_t stim_q[$];
   acc_t  exp_q[$];
   int    fd;
   int    num_cases    = 0;
   bit    cases_loaded = 1'b0;

   int beats_sent   = 0;
   int credits_back = 0;
   int grants       = 0;
   int results      = 0;
   int cases_done   = 0;

   corr_top #(
      .PE_NUM        (PE_NUM),
      .REG_NUM       (REG_NUM),
      .INGRESS_DEPTH (INGRESS_DEPTH)
   ) DUT (
      .clk        (clk),
      .rst        (rst),
      .in_valid   (in_valid),
      .in_data    (in_data),
      .in_credit  (in_credit),
      .out_valid  (out_valid),
      .out_data   (out_data),
      .out_credit (out_credit)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   //////////////////////////////////////////////////
   // reporting and checks
   //////////////////////////////////////////////////
   task automatic report_fail(input string line);
      $display("%s", line);
      $display("Testbench failed");
      $fatal(1);
   endtask

   task automatic check_result(input result_t got, input result_t want);
      if (got !== want) begin
         report_fail($sformatf(
            "FAIL %0t: result %0d got pe %0d (%0d, %0d), want pe %0d (%0d, %0d)",
            $time, results, got.pe_idx, got.value.re, got.value.im,
            want.pe_idx, want.value.re, want.value.im));
      end
   endtask

   task automatic check_credits(input int held, input int case_idx);
      if (held != INGRESS_DEPTH) begin
         report_fail($sformatf("FAIL %0t: after case %0d upstream holds %0d credits, want %0d",
            $time, case_idx, held, INGRESS_DEPTH));
      end
   endtask

   // credits upstream holds right now
   function automatic int credits_held();
      return INGRESS_DEPTH - beats_sent + credits_back;
   endfunction

   //////////////////////////////////////////////////
   // case file
   //////////////////////////////////////////////////

   // next word of the file, comment lines skipped
   task automatic next_token(output string tok);
      int    code;
      string line;
      code = $fscanf(fd, "%s", tok);
      while (code == 1 && tok.substr(0, 0) == "#") begin
         code = $fgets(line, fd);
         code = $fscanf(fd, "%s", tok);
      end
      if (code != 1) begin
         tok = "";
      end
   endtask

   task automatic load_cases();
      string                   tok;
      logic [2*DATA_WIDTH-1:0] word;
      int                      re_v;
      int                      im_v;
      int                      bad;
      acc_t                    val;
      bad = 0;
      fd  = $fopen("dv/corr_cases.txt", "r");
      if (fd == 0) begin
         report_fail("cannot open the case file dv/corr_cases.txt");
      end else begin
         next_token(tok);
         while (tok != "") begin
            // samples then coefficients, hex
            for (int w = 0; w < WORDS; w++) begin
               if (w > 0) begin
                  next_token(tok);
               end
               if ($sscanf(tok, "%h", word) != 1) begin
                  bad++;
               end
               stim_q.push_back(word);
            end
            // expected re and im per pe, signed decimal
            for (int p = 0; p < PE_NUM; p++) begin
               next_token(tok);
               if ($sscanf(tok, "%d", re_v) != 1) begin
                  bad++;
               end
               next_token(tok);
               if ($sscanf(tok, "%d", im_v) != 1) begin
                  bad++;
               end
               val.re = ACC_WIDTH'(re_v);
               val.im = ACC_WIDTH'(im_v);
               exp_q.push_back(val);
            end
            num_cases++;
            next_token(tok);
         end
         $fclose(fd);
      end
      if (bad != 0 || num_cases == 0) begin
         report_fail("the case file is empty or holds a malformed case");
      end
   endtask

   //////////////////////////////////////////////////
   // upstream driver
   //////////////////////////////////////////////////

   // random gap, then one beat once a credit is held
   task automatic drive_word(input cplx_t w);
      int gap;
      gap = $urandom_range(0, 2);
      while (gap > 0 || credits_held() == 0) begin
         @(posedge clk);
         in_valid <= 1'b0;
         if (gap > 0) begin
            gap--;
         end
      end
      @(posedge clk);
      in_valid <= 1'b1;
      in_data  <= w;
      beats_sent++;
   endtask

   task automatic drive_idle();
      @(posedge clk);
      in_valid <= 1'b0;
   endtask

   // credit pulses are registered, sampled mid cycle
   always @(negedge clk) begin
      if (!rst && in_credit) begin
         credits_back++;
      end
   end

   //////////////////////////////////////////////////
   // downstream sink
   //////////////////////////////////////////////////

   // sparse grants, never more than the cap outstanding
   initial begin
      forever begin
         @(posedge clk);
         if (!rst && (grants - results) < OUT_CREDIT_CAP && $urandom_range(0, 4) == 0) begin
            out_credit <= 1'b1;
            grants++;
         end else begin
            out_credit <= 1'b0;
         end
      end
   end

   // results in pe order, case after case
   initial begin
      result_t want;
      wait (cases_loaded);
      while (results < num_cases * PE_NUM) begin
         @(negedge clk);
         if (out_valid) begin
            if (results >= grants) begin
               report_fail($sformatf("FAIL %0t: result %0d sent with only %0d credits granted",
                  $time, results, grants));
            end
            want.pe_idx = PE_IDX_WIDTH'(results % PE_NUM);
            want.value  = exp_q[results];
            check_result(out_data, want);
            results++;
            if (results % PE_NUM == 0) begin
               cases_done++;
            end
         end
      end
   end

   initial begin
      wait (cases_loaded);
      repeat (16 + num_cases * (WORDS + N + PE_NUM) * 40) @(posedge clk);
      report_fail("timeout: results stopped arriving before all cases finished");
   end

   //////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////
   initial begin
      void'($urandom(69811));
      rst        = 1'b1;
      in_valid   = 1'b0;
      in_data    = '0;
      out_credit = 1'b0;
      load_cases();
      cases_loaded = 1'b1;
      repeat (16) @(posedge clk);
      rst <= 1'b0;
      for (int c = 0; c < num_cases; c++) begin
         for (int w = 0; w < WORDS; w++) begin
            drive_word(stim_q[c * WORDS + w]);
         end
         // even cases run straight into the next one
         if (c % 2 == 1 || c == num_cases - 1) begin
            drive_idle();
            while (cases_done <= c) begin
               @(posedge clk);
            end
            check_credits(credits_held(), c);
         end
      end
      $display("Testbench passed");
      $finish;
   end

endmodule

// ==== dv/corr_cases.txt ====
# per case: 16 sample words y[0..15], then 16 coefficient words h[0..15], hex {re,im}
# then 4 expected pairs re im for pe 0..3, signed decimal
# impulse at h[0], taps read y[4p]
853C 1122 3344 5566 7F80 1234 5678 9ABC F00F DEAD BEEF 0123 807F 4567 89AB CDEF
0100 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
-123 60 127 -128 -16 15 -128 127
# h[1] = 1 and h[15] = j, checks the rotation direction
853C 1122 3344 5566 7F80 1234 5678 9ABC F00F DEAD BEEF 0123 807F 4567 89AB CDEF
0000 0100 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0001
34 -17 -84 137 34 -185 34 104
# mixed signed data, three complex coefficients
03FE FB07 0A01 FFF7 0604 F802 000B 0CFD F9FA 0205 09F4 FC03 0108 F5FF 04F6 0706
0000 0000 0203 0000 0000 0000 0000 FD01 0000 0000 0000 0000 0000 01FC 0000 0000
-31 96 -1 36 27 26 72 15
# full range, y = h = -128-128j
8080 8080 8080 8080 8080 8080 8080 8080 8080 8080 8080 8080 8080 8080 8080 8080
8080 8080 8080 8080 8080 8080 8080 8080 8080 8080 8080 8080 8080 8080 8080 8080
0 524288 0 524288 0 524288 0 524288
# full range, y = -128-128j, h = 127-128j
8080 8080 8080 8080 8080 8080 8080 8080 8080 8080 8080 8080 8080 8080 8080 8080
7F80 7F80 7F80 7F80 7F80 7F80 7F80 7F80 7F80 7F80 7F80 7F80 7F80 7F80 7F80 7F80
-522240 2048 -522240 2048 -522240 2048 -522240 2048
# ramp y[k] = k, real window on h[0..3], j window on h[8..11]
0000 0100 0200 0300 0400 0500 0600 0700 0800 0900 0A00 0B00 0C00 0D00 0E00 0F00
0100 0100 0100 0100 0000 0000 0000 0000 0001 0001 0001 0001 0000 0000 0000 0000
6 38 22 54 38 6 54 22

// ==== list.f ====
design/corr_pkg.sv
design/credit_ingress.sv
design/sample_ring.sv
design/pe_array.sv
design/result_egress.sv
design/corr_top.sv
dv/corr_tb.sv

// ==== Bender.yml ====
package:
  name: block_corr

sources:
  - files:
      - design/corr_pkg.sv
      - design/credit_ingress.sv
      - design/sample_ring.sv
      - design/pe_array.sv
      - design/result_egress.sv
      - design/corr_top.sv
  - target: simulation
    files:
      - dv/corr_tb.sv
